// File: design/credit_pkg.sv
package credit_pkg;

    // allocation state of one output VC
    typedef enum logic {
        OVC_FREE      = 1'b0, // no packet owns the OVC
        OVC_ALLOCATED = 1'b1  // held until the tail flit leaves
    } ovc_state_e;

    // one counter step per cycle
    typedef enum logic [1:0] {
        CREDIT_HOLD = 2'd0, // no event, or credit and decrement together
        CREDIT_INC  = 2'd1, // credit back from downstream
        CREDIT_DEC  = 2'd2  // flit sent or head claimed by allocation
    } credit_op_e;

    // default router sizes
    parameter int DEFAULT_V = 2; // virtual channels per port
    parameter int DEFAULT_P = 5; // router ports
    parameter int DEFAULT_B = 4; // flit buffers per VC downstream

endpackage

// File: design/grant_decoder.sv
`timescale 1ns/10ps

module grant_decoder #(
    parameter int V       = credit_pkg::DEFAULT_V,
    parameter int P       = credit_pkg::DEFAULT_P,
    parameter int PORT_ID = 0
) (
    input  logic [V-1:0]   granted_ivc_i,       // one-hot, may be zero
    input  logic [V-1:0]   flit_is_tail_i,
    input  logic [V-1:0]   ovc_is_assigned_i,
    input  logic [V*V-1:0] assigned_ovc_num_i,  // one-hot OVC per input VC
    input  logic [P-2:0]   granted_dest_port_i, // relative, own port left out
    output logic [P*V-1:0] credit_dec_o,        // absolute OVC index
    output logic [P*V-1:0] ovc_release_o
);

    localparam int PV = P * V;

    logic [V-1:0]  granted_ovc;  // OVC of the granted input VC
    logic          granted_tail;
    logic [PV-1:0] dec_vec;

    // one-hot mux over the input VCs of this port
    always_comb begin
        granted_ovc  = '0;
        granted_tail = 1'b0;
        for (int i = 0; i < V; i++) begin
            if (granted_ivc_i[i]) begin
                if (ovc_is_assigned_i[i]) begin
                    granted_ovc = granted_ovc | assigned_ovc_num_i[i*V +: V];
                end
                granted_tail = granted_tail | flit_is_tail_i[i];
            end
        end
    end

    // place the OVC bits at the absolute output port
    always_comb begin
        int abs_port;
        dec_vec = '0;
        for (int j = 0; j < P - 1; j++) begin
            abs_port = (j < PORT_ID) ? j : j + 1; // skip the source port
            if (granted_dest_port_i[j]) begin
                dec_vec[abs_port*V +: V] = granted_ovc;
            end
        end
    end

    assign credit_dec_o  = dec_vec;
    assign ovc_release_o = granted_tail ? dec_vec : '0; // tail frees the OVC

endmodule

// File: design/ovc_state_ctrl.sv
`timescale 1ns/10ps

module ovc_state_ctrl #(
    parameter int V = credit_pkg::DEFAULT_V,
    parameter int P = credit_pkg::DEFAULT_P,
    parameter int B = credit_pkg::DEFAULT_B
) (
    input  logic           clk,
    input  logic           reset,
    input  logic [P*V-1:0] credit_in_i,
    input  logic [P*V-1:0] credit_dec_i,    // merged switch grants
    input  logic [P*V-1:0] ovc_release_i,   // tail flit left
    input  logic [P*V-1:0] ovc_allocated_i, // head claims the OVC
    output logic [P*V-1:0] full_o,
    output logic [P*V-1:0] nearly_full_o,
    output logic [P*V-1:0] ovc_available_o
);

    localparam int PV = P * V;
    localparam int CW = $clog2(B + 1);
    localparam logic [CW-1:0] B_CNT = CW'(B);

    logic [CW-1:0]          credit_cnt_q    [PV];
    logic [CW-1:0]          credit_cnt_next [PV];
    credit_pkg::credit_op_e credit_op       [PV];
    credit_pkg::ovc_state_e ovc_state_q     [PV];
    logic [PV-1:0]          full_q;
    logic [PV-1:0]          nearly_full_q;
    logic [PV-1:0]          full_next;
    logic [PV-1:0]          nearly_full_next;
    logic [PV-1:0]          dec_all;

    // allocation also takes the head flit's credit
    assign dec_all = credit_dec_i | ovc_allocated_i;

    always_comb begin
        for (int k = 0; k < PV; k++) begin
            if (credit_in_i[k] && !dec_all[k]) begin
                credit_op[k] = credit_pkg::CREDIT_INC;
            end else if (!credit_in_i[k] && dec_all[k]) begin
                credit_op[k] = credit_pkg::CREDIT_DEC;
            end else begin
                credit_op[k] = credit_pkg::CREDIT_HOLD; // both cancel out
            end
            case (credit_op[k])
                credit_pkg::CREDIT_INC:  credit_cnt_next[k] = credit_cnt_q[k] + 1'b1;
                credit_pkg::CREDIT_DEC:  credit_cnt_next[k] = credit_cnt_q[k] - 1'b1;
                default:                 credit_cnt_next[k] = credit_cnt_q[k];
            endcase
            full_next[k]        = (credit_cnt_next[k] == '0);
            nearly_full_next[k] = (credit_cnt_next[k] <= CW'(1));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < PV; k++) begin
                credit_cnt_q[k] <= B_CNT;                // all buffers empty
                ovc_state_q[k]  <= credit_pkg::OVC_FREE;
            end
            full_q        <= '0;
            nearly_full_q <= '0;
        end else begin
            for (int k = 0; k < PV; k++) begin
                credit_cnt_q[k] <= credit_cnt_next[k];
                if (ovc_allocated_i[k]) begin
                    ovc_state_q[k] <= credit_pkg::OVC_ALLOCATED; // wins over release
                end else if (ovc_release_i[k]) begin
                    ovc_state_q[k] <= credit_pkg::OVC_FREE;
                end
            end
            full_q        <= full_next;        // flags track the counter
            nearly_full_q <= nearly_full_next;
        end
    end

    // non-atomic reuse, free and room for more than one flit
    always_comb begin
        for (int k = 0; k < PV; k++) begin
            ovc_available_o[k] = (ovc_state_q[k] == credit_pkg::OVC_FREE) && !nearly_full_q[k];
        end
    end

    assign full_o        = full_q;
    assign nearly_full_o = nearly_full_q;

endmodule

// File: design/full_mask_gen.sv
`timescale 1ns/10ps

module full_mask_gen #(
    parameter int V       = credit_pkg::DEFAULT_V,
    parameter int P       = credit_pkg::DEFAULT_P,
    parameter int PORT_ID = 0
) (
    input  logic           clk,
    input  logic           reset,
    input  logic [P*V-1:0] full_i,
    input  logic [P*V-1:0] nearly_full_i,
    input  logic [P*V-1:0] credit_in_i,
    input  logic [P-2:0]   dest_port_i,        // relative one-hot
    input  logic [V-1:0]   assigned_ovc_num_i, // one-hot
    input  logic           ivc_sw_grant_i,     // this input VC sends now
    output logic           assigned_ovc_not_full_o
);

    localparam int PV = P * V;

    logic [PV-1:0] full_nc;        // full with no credit arriving
    logic [PV-1:0] nearly_full_nc;
    logic [V-1:0]  full_port;      // flags of the destination port
    logic [V-1:0]  nearly_full_port;
    logic          full_hit;
    logic          nearly_full_hit;
    logic          mask_q;

    // an arriving credit lifts the OVC out of full
    assign full_nc        = full_i & ~credit_in_i;
    assign nearly_full_nc = nearly_full_i & ~credit_in_i;

    // destination port mux, own port is not in dest_port_i
    always_comb begin
        int abs_port;
        full_port        = '0;
        nearly_full_port = '0;
        for (int j = 0; j < P - 1; j++) begin
            abs_port = (j < PORT_ID) ? j : j + 1;
            if (dest_port_i[j]) begin
                full_port        = full_port | full_nc[abs_port*V +: V];
                nearly_full_port = nearly_full_port | nearly_full_nc[abs_port*V +: V];
            end
        end
    end

    // assigned OVC select
    assign full_hit        = |(full_port & assigned_ovc_num_i);
    assign nearly_full_hit = |(nearly_full_port & assigned_ovc_num_i) & ivc_sw_grant_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mask_q <= 1'b0;
        end else begin
            mask_q <= full_hit | nearly_full_hit; // last credit in flight
        end
    end

    assign assigned_ovc_not_full_o = ~mask_q;

endmodule

// File: design/credit_counter_top.sv
`timescale 1ns/10ps

module credit_counter_top #(
    parameter int V = credit_pkg::DEFAULT_V,
    parameter int P = credit_pkg::DEFAULT_P,
    parameter int B = credit_pkg::DEFAULT_B
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [P*V-1:0]           ovc_allocated_i,     // from VC allocator
    input  logic [P*V-1:0]           credit_in_i,         // from downstream
    input  logic [P*V-1:0]           granted_ivc_i,       // one-hot per input port
    input  logic [P*(P-1)-1:0]       granted_dest_port_i, // one-hot over other ports
    input  logic [P*V-1:0]           flit_is_tail_i,
    input  logic [P*V-1:0]           ovc_is_assigned_i,
    input  logic [P*V*V-1:0]         assigned_ovc_num_i,  // one-hot per input VC
    input  logic [P*V*(P-1)-1:0]     dest_port_i,
    input  logic [P*V-1:0]           ivc_sw_grant_i,
    output logic [P*V-1:0]           ovc_available_o,
    output logic [P*V-1:0]           assigned_ovc_not_full_o
);

    localparam int PV = P * V;
    localparam int P1 = P - 1;

    logic [PV-1:0] dec_per_port [P]; // each input port's share
    logic [PV-1:0] rel_per_port [P];
    logic [PV-1:0] credit_dec;
    logic [PV-1:0] ovc_release;
    logic [PV-1:0] full;
    logic [PV-1:0] nearly_full;

    // grants come from one input port at a time per output, merge them
    always_comb begin
        credit_dec  = '0;
        ovc_release = '0;
        for (int p = 0; p < P; p++) begin
            credit_dec  = credit_dec | dec_per_port[p];
            ovc_release = ovc_release | rel_per_port[p];
        end
    end

    for (genvar p = 0; p < P; p++) begin : g_port
        grant_decoder #(
            .V       (V),
            .P       (P),
            .PORT_ID (p)
        ) i_grant_decoder (
            .granted_ivc_i       (granted_ivc_i[p*V +: V]),
            .flit_is_tail_i      (flit_is_tail_i[p*V +: V]),
            .ovc_is_assigned_i   (ovc_is_assigned_i[p*V +: V]),
            .assigned_ovc_num_i  (assigned_ovc_num_i[p*V*V +: V*V]),
            .granted_dest_port_i (granted_dest_port_i[p*P1 +: P1]),
            .credit_dec_o        (dec_per_port[p]),
            .ovc_release_o       (rel_per_port[p])
        );
    end

    ovc_state_ctrl #(
        .V (V),
        .P (P),
        .B (B)
    ) i_ovc_state_ctrl (
        .clk             (clk),
        .reset           (reset),
        .credit_in_i     (credit_in_i),
        .credit_dec_i    (credit_dec),
        .ovc_release_i   (ovc_release),
        .ovc_allocated_i (ovc_allocated_i),
        .full_o          (full),
        .nearly_full_o   (nearly_full),
        .ovc_available_o (ovc_available_o)
    );

    for (genvar k = 0; k < PV; k++) begin : g_ivc
        full_mask_gen #(
            .V       (V),
            .P       (P),
            .PORT_ID (k / V) // input port of this VC
        ) i_full_mask_gen (
            .clk                     (clk),
            .reset                   (reset),
            .full_i                  (full),
            .nearly_full_i           (nearly_full),
            .credit_in_i             (credit_in_i),
            .dest_port_i             (dest_port_i[k*P1 +: P1]),
            .assigned_ovc_num_i      (assigned_ovc_num_i[k*V +: V]),
            .ivc_sw_grant_i          (ivc_sw_grant_i[k]),
            .assigned_ovc_not_full_o (assigned_ovc_not_full_o[k])
        );
    end

endmodule

// File: dv/credit_counter_chk.sv
`timescale 1ns/10ps

module credit_counter_chk #(
    parameter int V = credit_pkg::DEFAULT_V,
    parameter int P = credit_pkg::DEFAULT_P,
    parameter int B = credit_pkg::DEFAULT_B
) (
    input logic                   clk,
    input logic                   reset,
    input logic [$clog2(B+1)-1:0] credit_cnt_i [P*V],
    input credit_pkg::credit_op_e credit_op_i  [P*V],
    input credit_pkg::ovc_state_e ovc_state_i  [P*V],
    input logic [P*V-1:0]         full_i,
    input logic [P*V-1:0]         nearly_full_i,
    input logic [P*V-1:0]         ovc_available_i
);

    localparam int PV = P * V;
    localparam int CW = $clog2(B + 1);

    for (genvar k = 0; k < PV; k++) begin : g_ovc
        assert property (@(posedge clk) disable iff (reset) credit_cnt_i[k] <= CW'(B))
            else $error("credit counter of OVC %0d above buffer depth", k);

        // upstream must hold back flits when no credit is left
        assert property (@(posedge clk) disable iff (reset)
            credit_op_i[k] == credit_pkg::CREDIT_DEC |-> credit_cnt_i[k] != '0)
            else $error("credit counter of OVC %0d decremented at zero", k);

        // flags come from the next count and line up with the counter
        assert property (@(posedge clk) disable iff (reset)
            full_i[k] |-> nearly_full_i[k] && credit_cnt_i[k] == '0)
            else $error("OVC %0d full without nearly full or with credits left", k);

        assert property (@(posedge clk) disable iff (reset)
            ovc_available_i[k] |-> ovc_state_i[k] == credit_pkg::OVC_FREE
                && credit_cnt_i[k] > CW'(1))
            else $error("OVC %0d available while allocated or short of credits", k);
    end

    assert property (@(posedge clk) $fell(reset) |-> &ovc_available_i)
        else $error("not every OVC available in the first cycle after reset");

endmodule

bind ovc_state_ctrl credit_counter_chk #(
    .V (V),
    .P (P),
    .B (B)
) i_credit_counter_chk (
    .clk             (clk),
    .reset           (reset),
    .credit_cnt_i    (credit_cnt_q),
    .credit_op_i     (credit_op),
    .ovc_state_i     (ovc_state_q),
    .full_i          (full_q),
    .nearly_full_i   (nearly_full_q),
    .ovc_available_i (ovc_available_o)
);

// File: dv/credit_counter_tb.sv
`timescale 1ns/10ps

module credit_counter_tb;

    localparam int V  = credit_pkg::DEFAULT_V;
    localparam int P  = credit_pkg::DEFAULT_P;
    localparam int PV = P * V;
    localparam int P1 = P - 1;

    localparam int    CLK_PERIOD     = 40;
    localparam int    RESET_CYCLES   = 16;
    localparam int    TIMEOUT_MARGIN = 20; // extra cycles before the watchdog fires
    localparam int    NUM_COLS       = 12; // hex words per vector line
    localparam int    MAX_VECS       = 64;
    localparam string INPUT_FILE     = "dv/credit_counter_input.txt";

    logic              clk;
    logic              reset;
    logic [PV-1:0]     ovc_allocated_i;
    logic [PV-1:0]     credit_in_i;
    logic [PV-1:0]     granted_ivc_i;
    logic [P*P1-1:0]   granted_dest_port_i;
    logic [PV-1:0]     flit_is_tail_i;
    logic [PV-1:0]     ovc_is_assigned_i;
    logic [PV*V-1:0]   assigned_ovc_num_i;
    logic [PV*P1-1:0]  dest_port_i;
    logic [PV-1:0]     ivc_sw_grant_i;
    logic [PV-1:0]     ovc_available_o;
    logic [PV-1:0]     assigned_ovc_not_full_o;

    logic [63:0] vec_mem [NUM_COLS*MAX_VECS];
    int          num_vecs    = 0;
    int          error_count = 0;
    int          check_count = 0;

    credit_counter_top i_credit_counter_top (
        .clk                     (clk),
        .reset                   (reset),
        .ovc_allocated_i         (ovc_allocated_i),
        .credit_in_i             (credit_in_i),
        .granted_ivc_i           (granted_ivc_i),
        .granted_dest_port_i     (granted_dest_port_i),
        .flit_is_tail_i          (flit_is_tail_i),
        .ovc_is_assigned_i       (ovc_is_assigned_i),
        .assigned_ovc_num_i      (assigned_ovc_num_i),
        .dest_port_i             (dest_port_i),
        .ivc_sw_grant_i          (ivc_sw_grant_i),
        .ovc_available_o         (ovc_available_o),
        .assigned_ovc_not_full_o (assigned_ovc_not_full_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic drive_idle();
        ovc_allocated_i     = '0;
        credit_in_i         = '0;
        granted_ivc_i       = '0;
        granted_dest_port_i = '0;
        flit_is_tail_i      = '0;
        ovc_is_assigned_i   = '0;
        assigned_ovc_num_i  = '0;
        dest_port_i         = '0;
        ivc_sw_grant_i      = '0;
    endtask

    // column 0 is the valid flag, see the data file
    task automatic apply_vector(input int n);
        int base;
        base = n * NUM_COLS;
        ovc_allocated_i     = vec_mem[base + 1][PV-1:0];
        credit_in_i         = vec_mem[base + 2][PV-1:0];
        granted_ivc_i       = vec_mem[base + 3][PV-1:0];
        granted_dest_port_i = vec_mem[base + 4][P*P1-1:0];
        flit_is_tail_i      = vec_mem[base + 5][PV-1:0];
        ovc_is_assigned_i   = vec_mem[base + 6][PV-1:0];
        assigned_ovc_num_i  = vec_mem[base + 7][PV*V-1:0];
        dest_port_i         = vec_mem[base + 8][PV*P1-1:0];
        ivc_sw_grant_i      = vec_mem[base + 9][PV-1:0];
    endtask

    task automatic check_outputs(input int n);
        logic [PV-1:0] exp_avail;
        logic [PV-1:0] exp_not_full;
        exp_avail    = vec_mem[n*NUM_COLS + 10][PV-1:0];
        exp_not_full = vec_mem[n*NUM_COLS + 11][PV-1:0];
        check_count  = check_count + 2;
        assert (ovc_available_o === exp_avail) else begin
            error_count++;
            $display("** Error: ovc_available_o vector %0d expected %h got %h",
                     n, exp_avail, ovc_available_o);
        end
        assert (assigned_ovc_not_full_o === exp_not_full) else begin
            error_count++;
            $display("** Error: assigned_ovc_not_full_o vector %0d expected %h got %h",
                     n, exp_not_full, assigned_ovc_not_full_o);
        end
    endtask

    function automatic int count_vectors();
        int cnt;
        cnt = 0;
        while (cnt < MAX_VECS && vec_mem[cnt*NUM_COLS] === 64'd1) begin
            cnt++;
        end
        return cnt;
    endfunction

    initial begin
        drive_idle();
        reset = 1'b1;
        $readmemh(INPUT_FILE, vec_mem);
        num_vecs = count_vectors();
        if (num_vecs == 0) begin
            error_count++;
            $display("no stimulus vectors could be read from %s", INPUT_FILE);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < num_vecs; n++) begin
            @(negedge clk);
            if (n > 0) begin
                check_outputs(n - 1); // outputs settled since the rising edge
            end
            apply_vector(n);
        end
        if (num_vecs > 0) begin
            @(negedge clk);
            check_outputs(num_vecs - 1);
        end
        $display("%0d vectors, %0d checks, %0d errors", num_vecs, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (num_vecs > 0);
        #((num_vecs + RESET_CYCLES + TIMEOUT_MARGIN) * CLK_PERIOD);
        $display("timeout: the vectors did not complete in the expected time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: credit_counter_top.f
design/credit_pkg.sv
design/grant_decoder.sv
design/ovc_state_ctrl.sv
design/full_mask_gen.sv
design/credit_counter_top.sv
dv/credit_counter_chk.sv
dv/credit_counter_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the credit counter testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
    --top-module credit_counter_tb \
    -f credit_counter_top.f

sim_output=$(./obj_dir/Vcredit_counter_tb 2>&1) || true
echo "$sim_output"

if grep -q "^TEST RESULT: PASS$" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi

// File: dv/credit_counter_input.txt
// one cycle per line, hex: valid alloc credit gnt_ivc gnt_dest tail assigned
// ovc_num dest_port sw_grant exp_avail exp_not_full
1 000 000 000 00000 000 041 01001 0004000002 000 3ff 3ff // idle after reset
1 080 000 000 00000 000 041 01001 0004000002 000 37f 3ff // allocate OVC 7
1 000 000 000 00000 000 041 01001 0004000002 000 37f 3ff
1 010 000 000 00000 000 041 01001 0004000002 000 36f 3ff // allocate OVC 4
1 000 000 001 00002 000 041 01001 0004000002 001 36f 3ff // port 0 to port 2
1 000 000 040 04000 000 041 01001 0004000002 040 36f 3ff // port 3 to port 2
1 000 000 001 00002 000 041 01001 0004000002 001 36f 3fe // granted while nearly full
1 000 000 000 00000 000 041 01001 0004000002 000 36f 3be // OVC 4 full
1 000 010 000 00000 000 041 01001 0004000002 000 36f 3ff // credit lifts the mask
1 000 000 040 04000 040 041 01001 0004000002 040 36f 3bf // tail releases OVC 4
1 000 010 000 00000 000 041 01001 0004000002 000 36f 3ff
1 000 010 000 00000 000 041 01001 0004000002 000 37f 3ff // OVC 4 available again
1 000 010 001 00002 000 041 01001 0004000002 001 37f 3ff // credit and grant cancel
1 000 010 000 00000 000 041 01001 0004000002 000 37f 3ff
1 000 090 000 00000 000 041 01001 0004000002 000 37f 3ff // OVC 4 and 7 back to B
1 010 000 001 00002 001 041 01001 0004000002 001 36f 3ff // allocation beats release
1 000 000 001 00002 001 041 01001 0004000002 001 37f 3ff // tail frees OVC 4
1 000 010 000 00000 000 041 01001 0004000002 000 37f 3ff
1 000 010 000 00000 000 041 01001 0004000002 000 37f 3ff
1 000 000 000 00000 000 041 01001 0004000002 000 37f 3ff
